/* hw/cart_mapper_params.svh */
`ifndef CART_MAPPER_PARAMS_SVH
`define CART_MAPPER_PARAMS_SVH

// CPU side address bus
`define CPU_ADDR_W 16

// One bank register, also the CPU data byte
`define BANK_W 8

// Flat ROM byte address, 8K bank granularity
`define ROM_ADDR_W (`BANK_W + 13)

// Region 4 bank value that maps the sound chip window
`define SCC_BANK 8'h3F

// Bank slot k comes out of reset on bank k, ROM looks linear
`define RESET_BANK(idx) (`BANK_W'(idx))

`endif

/* hw/cart_mapper_pkg.sv */
`default_nettype none

`include "cart_mapper_params.svh"

package cart_mapper_pkg;

    // Mapper selected for the block
    typedef enum logic [2:0] {
        map_linear,
        map_ascii8,
        map_ascii16,
        map_konami,
        map_konami_scc
    } mapper_type_e;

    typedef struct packed {
        mapper_type_e mapper;
        logic         enable;     // Cartridge present in slot
    } block_cfg_t;

    // 16K page view, ASCII16 and linear
    typedef struct packed {
        logic [1:0]               page;
        logic [`CPU_ADDR_W-3:0]   offset;
    } cpu_page_t;

    // 8K region view, ASCII8 and Konami
    typedef struct packed {
        logic [2:0]               region;
        logic [`CPU_ADDR_W-4:0]   offset;
    } cpu_region_t;

    typedef union packed {
        cpu_page_t   pg;
        cpu_region_t rg;
    } cpu_addr_u;

    typedef struct packed {
        cpu_addr_u  addr;
        logic [7:0] data;
        logic       rnw;          // 1 = read
    } cpu_req_t;

    typedef struct packed {
        logic [`ROM_ADDR_W-1:0] addr;
        logic                   rom_cs;
        logic                   scc_cs;
    } mem_req_t;

    // Neutral output, address ANDed and selects ORed across mappers
    localparam mem_req_t MEM_IDLE = '{addr: '1, rom_cs: 1'b0, scc_cs: 1'b0};

endpackage

`default_nettype wire

/* hw/cart_req_capture.sv */
`default_nettype none

module cart_req_capture (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    input  wire logic                    req,        // Four-phase request from host
    input  wire cart_mapper_pkg::cpu_req_t cpu_req,  // Stable while req high
    input  wire logic                    map_valid,  // Mapper stage result ready
    output logic                         ack,
    output logic                         cap_valid,  // One-cycle pulse
    output cart_mapper_pkg::cpu_req_t    cap_req
);

    logic req_q;     // req seen at last edge
    logic busy_q;    // Access in flight until req drops
    logic start;
    logic release_ack;

    // Rising req while idle starts one access
    assign start       = req & ~req_q & ~busy_q;
    assign release_ack = ack & ~req;     // Host has dropped req

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_q     <= 1'b0;
            busy_q    <= 1'b0;
            cap_valid <= 1'b0;
            ack       <= 1'b0;
        end else begin
            req_q     <= req;
            cap_valid <= start;
            if (start) begin
                busy_q <= 1'b1;
            end else if (release_ack) begin
                busy_q <= 1'b0;   // Idle again until the next req edge
            end
            if (map_valid) begin
                ack <= 1'b1;      // Two edges after req sampled
            end else if (release_ack) begin
                ack <= 1'b0;
            end
        end
    end

    // Request payload held for the mapper stage
    always_ff @(posedge clk) begin
        if (start) begin
            cap_req <= cpu_req;
        end
    end

endmodule

`default_nettype wire

/* hw/mapper_ascii.sv */
`default_nettype none

`include "cart_mapper_params.svh"

module mapper_ascii #(
    parameter bit REGION_13 = 1'b1        // 1: ASCII8 8K regions, 0: ASCII16 16K pages
) (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire logic                      active,     // This mapper selected and enabled
    input  wire logic                      req_valid,
    input  wire cart_mapper_pkg::cpu_req_t req,
    output cart_mapper_pkg::mem_req_t      out
);

    import cart_mapper_pkg::*;

    localparam int NUM_BANKS = REGION_13 ? 4 : 2;
    localparam int IDX_W     = REGION_13 ? 2 : 1;

    logic [`BANK_W-1:0] bank_q [NUM_BANKS];
    logic               in_range;
    logic               wr_hit;
    logic [IDX_W-1:0]   wr_idx;
    logic [IDX_W-1:0]   rd_idx;
    logic [`BANK_W-1:0] rd_bank;

    // Pages 1 and 2 only, 0x4000-0xBFFF
    assign in_range = (req.addr.pg.page == 2'd1) || (req.addr.pg.page == 2'd2);

    // Register window 0x6000-0x7FFF
    // ASCII16 decodes only the lower 2K of each 4K half
    assign wr_hit = !req.rnw && (req.addr.rg.region == 3'b011)
                    && (REGION_13 || !req.addr.rg.offset[11]);
    assign wr_idx = req.addr.rg.offset[12 -: IDX_W];   // A12:A11 or A12

    // Slot 0 is region 2 or page 1
    assign rd_idx  = REGION_13 ? IDX_W'(req.addr.rg.region - 3'd2)
                               : IDX_W'(req.addr.pg.page - 2'd1);
    assign rd_bank = bank_q[rd_idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_BANKS; i++) begin
                bank_q[i] <= `RESET_BANK(i);
            end
        end else if (active && req_valid && wr_hit) begin
            bank_q[wr_idx] <= req.data;    // Bank number from data byte
        end
    end

    always_comb begin
        out = MEM_IDLE;                    // Inactive or write
        if (active && req.rnw && in_range) begin
            out.rom_cs = 1'b1;
            // ASCII16 drops the bank MSB, 16K banks fill 21 bits with 7
            out.addr = REGION_13 ? {rd_bank, req.addr.rg.offset}
                                 : {rd_bank[`BANK_W-2:0], req.addr.pg.offset};
        end
    end

endmodule

`default_nettype wire

/* hw/mapper_konami.sv */
`default_nettype none

`include "cart_mapper_params.svh"

module mapper_konami #(
    parameter bit WITH_SCC = 1'b0         // 1: SCC write layout and sound window
) (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire logic                      active,
    input  wire logic                      req_valid,
    input  wire cart_mapper_pkg::cpu_req_t req,
    output cart_mapper_pkg::mem_req_t      out
);

    import cart_mapper_pkg::*;

    logic [`BANK_W-1:0] bank_q [4];       // Regions 2 to 5
    logic [2:0]         region;
    logic [1:0]         idx;
    logic               in_range;
    logic               wr_sel;
    logic               wr_hit;
    logic               scc_hit;

    assign region   = req.addr.rg.region;
    assign idx      = 2'(region - 3'd2);
    assign in_range = (region >= 3'd2) && (region <= 3'd5);

    // SCC: 0x5000, 0x7000, 0x9000, 0xB000, 2K windows each
    // Plain: whole region 3 to 5, region 2 has no register
    assign wr_sel = WITH_SCC ? (req.addr.rg.offset[12:11] == 2'b10)
                             : (region != 3'd2);
    assign wr_hit = !req.rnw && in_range && wr_sel;

    // 0x9800-0x9FFF with region 4 on the SCC bank
    assign scc_hit = WITH_SCC && (region == 3'd4)
                     && (req.addr.rg.offset[12:11] == 2'b11)
                     && (bank_q[2] == `SCC_BANK);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 4; i++) begin
                bank_q[i] <= `RESET_BANK(i);    // Plain slot 0 stays 0
            end
        end else if (active && req_valid && wr_hit) begin
            bank_q[idx] <= req.data;
        end
    end

    always_comb begin
        out = MEM_IDLE;
        if (active && req.rnw && in_range) begin
            if (scc_hit) begin
                out.scc_cs = 1'b1;              // Sound chip instead of ROM
            end else begin
                out.rom_cs = 1'b1;
                out.addr   = {bank_q[idx], req.addr.rg.offset};
            end
        end
    end

endmodule

`default_nettype wire

/* hw/cart_mappers.sv */
`default_nettype none

`include "cart_mapper_params.svh"

module cart_mappers (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire cart_mapper_pkg::block_cfg_t cfg,   // Static between resets
    input  wire logic                      cap_valid,
    input  wire cart_mapper_pkg::cpu_req_t cap_req,
    output logic                           map_valid,
    output cart_mapper_pkg::mem_req_t      mem
);

    import cart_mapper_pkg::*;

    logic act_lin, act_a8, act_a16, act_kon, act_scc;   // One-hot or all low when disabled
    logic                   lin_range;
    logic [`CPU_ADDR_W-1:0] lin_off;
    mem_req_t lin_out, a8_out, a16_out, kon_out, scc_out;
    mem_req_t map_comb;

    assign act_lin = cfg.enable && (cfg.mapper == map_linear);
    assign act_a8  = cfg.enable && (cfg.mapper == map_ascii8);
    assign act_a16 = cfg.enable && (cfg.mapper == map_ascii16);
    assign act_kon = cfg.enable && (cfg.mapper == map_konami);
    assign act_scc = cfg.enable && (cfg.mapper == map_konami_scc);

    // Linear ROM starts at CPU address 0x4000
    assign lin_range = (cap_req.addr.pg.page == 2'd1) || (cap_req.addr.pg.page == 2'd2);
    assign lin_off   = cap_req.addr - 16'h4000;

    always_comb begin
        lin_out = MEM_IDLE;
        if (act_lin && cap_req.rnw && lin_range) begin
            lin_out.rom_cs = 1'b1;
            lin_out.addr   = `ROM_ADDR_W'(lin_off);
        end
    end

    mapper_ascii #(.REGION_13(1'b1)) mapper_ascii8_i (
        .clk, .arst_n, .active(act_a8), .req_valid(cap_valid), .req(cap_req), .out(a8_out)
    );

    mapper_ascii #(.REGION_13(1'b0)) mapper_ascii16_i (
        .clk, .arst_n, .active(act_a16), .req_valid(cap_valid), .req(cap_req), .out(a16_out)
    );

    mapper_konami #(.WITH_SCC(1'b0)) mapper_konami_i (
        .clk, .arst_n, .active(act_kon), .req_valid(cap_valid), .req(cap_req), .out(kon_out)
    );

    mapper_konami #(.WITH_SCC(1'b1)) mapper_konami_scc_i (
        .clk, .arst_n, .active(act_scc), .req_valid(cap_valid), .req(cap_req), .out(scc_out)
    );

    // Inactive blocks are neutral
    assign map_comb.addr   = lin_out.addr & a8_out.addr & a16_out.addr
                             & kon_out.addr & scc_out.addr;
    assign map_comb.rom_cs = lin_out.rom_cs | a8_out.rom_cs | a16_out.rom_cs
                             | kon_out.rom_cs | scc_out.rom_cs;
    assign map_comb.scc_cs = lin_out.scc_cs | a8_out.scc_cs | a16_out.scc_cs
                             | kon_out.scc_cs | scc_out.scc_cs;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            map_valid <= 1'b0;
            mem       <= MEM_IDLE;
        end else begin
            map_valid <= cap_valid;     // One cycle behind capture
            if (cap_valid) begin
                mem <= map_comb;        // Held until next access
            end
        end
    end

endmodule

`default_nettype wire

/* hw/cart_mapper_top.sv */
`default_nettype none

module cart_mapper_top (
    input  wire logic                        clk,
    input  wire logic                        arst_n,
    input  wire cart_mapper_pkg::block_cfg_t cfg,
    input  wire logic                        req,
    input  wire cart_mapper_pkg::cpu_req_t   cpu_req,
    output logic                             ack,
    output cart_mapper_pkg::mem_req_t        mem
);

    import cart_mapper_pkg::*;

    // Capture to mapper stage
    logic     cap_valid;
    cpu_req_t cap_req;
    logic     map_valid;    // Back to capture, raises ack

    cart_req_capture cart_req_capture_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .cpu_req   (cpu_req),
        .map_valid (map_valid),
        .ack       (ack),
        .cap_valid (cap_valid),
        .cap_req   (cap_req)
    );

    cart_mappers cart_mappers_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .cfg       (cfg),
        .cap_valid (cap_valid),
        .cap_req   (cap_req),
        .map_valid (map_valid),
        .mem       (mem)          // Stable while ack high
    );

endmodule

`default_nettype wire

/* dv/cart_mapper_checker.sv */
`default_nettype none

`include "cart_mapper_params.svh"

module cart_mapper_checker (
    input wire logic                        clk,
    input wire logic                        arst_n,
    input wire cart_mapper_pkg::block_cfg_t cfg,
    input wire logic                        req,
    input wire cart_mapper_pkg::cpu_req_t   cpu_req,
    input wire logic                        ack,
    input wire cart_mapper_pkg::mem_req_t   mem
);

    timeunit 1ns;
    timeprecision 100ps;

    import cart_mapper_pkg::*;

    logic [7:0] bank [4];          // Bank slots of the configured mapper
    mem_req_t   exp_mem;
    mem_req_t   held_mem;          // mem seen at ack rise
    logic       pending  = 1'b0;   // Request logged, ack not seen yet
    logic       acked    = 1'b0;
    logic       req_prev = 1'b0;
    logic       fresh    = 1'b0;   // First edge out of reset
    int         edges    = 0;
    int         checks   = 0;
    int         errors   = 0;

    task automatic compare_value(input string sig, input logic [31:0] got,
                                 input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", sig, got, want);
        end
    endtask

    task automatic report_failure(input string what);
        checks++;
        errors++;
        $display("%s", what);
    endtask

    // Expected memory request from the mapper rules
    function automatic mem_req_t expect_mem(input cpu_req_t r);
        mem_req_t    e;
        logic [15:0] a;
        logic [1:0]  k;
        int          flat;
        a    = r.addr;
        e    = '{addr: '0, rom_cs: 1'b0, scc_cs: 1'b0};
        flat = 0;
        k    = 2'(a[15:13] - 3'd2);       // 8K region 2..5 as slot 0..3
        if (cfg.enable && r.rnw && a >= 16'h4000 && a <= 16'hBFFF) begin
            e.rom_cs = 1'b1;
            case (cfg.mapper)
                map_linear: flat = int'(a) - 16384;
                map_ascii8: flat = int'(bank[k]) * 8192 + int'(a[12:0]);
                map_ascii16: begin
                    k    = 2'(a[15:14] - 2'd1);  // 16K page 1 or 2
                    flat = int'(bank[k]) * 16384 + int'(a[13:0]);
                end
                map_konami: flat = (k == 2'd0 ? 0 : int'(bank[k])) * 8192 + int'(a[12:0]);
                default: begin
                    flat = int'(bank[k]) * 8192 + int'(a[12:0]);
                    if (a >= 16'h9800 && a <= 16'h9FFF && bank[2] == `SCC_BANK) begin
                        e.rom_cs = 1'b0;     // Sound chip takes the read
                        e.scc_cs = 1'b1;
                    end
                end
            endcase
            e.addr = `ROM_ADDR_W'(flat);     // Wraps past the ROM size
        end
        return e;
    endfunction

    task automatic update_banks(input cpu_req_t r);
        logic [15:0] a;
        a = r.addr;
        if (cfg.enable && !r.rnw) begin
            case (cfg.mapper)
                map_ascii8: if (a >= 16'h6000 && a <= 16'h7FFF) begin
                    bank[2'((a - 16'h6000) >> 11)] = r.data;     // 2K per register
                end
                map_ascii16: if (a >= 16'h6000 && a <= 16'h67FF) begin
                    bank[0] = r.data;
                end else if (a >= 16'h7000 && a <= 16'h77FF) begin
                    bank[1] = r.data;
                end
                map_konami: if (a >= 16'h6000 && a <= 16'hBFFF) begin
                    bank[2'((a - 16'h4000) >> 13)] = r.data;     // Regions 3 to 5
                end
                map_konami_scc: if (a >= 16'h5000 && a <= 16'hB7FF && a[12:11] == 2'b10) begin
                    bank[2'((a - 16'h5000) >> 13)] = r.data;     // x000 to x7FF windows
                end
                default: ;
            endcase
        end
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 4; i++) begin
                bank[i] = 8'(i);                 // Slot i starts on bank i
            end
            pending  = 1'b0;
            acked    = 1'b0;
            req_prev = 1'b0;
            fresh    = 1'b1;
        end else begin
            if (fresh) begin
                compare_value("ack after reset", 32'(ack), 32'h0);
                compare_value("mem.rom_cs after reset", 32'(mem.rom_cs), 32'h0);
                compare_value("mem.scc_cs after reset", 32'(mem.scc_cs), 32'h0);
                fresh = 1'b0;
            end
            // Values read here are the ones set at the previous edge
            if (req && !req_prev && !pending && !acked) begin
                exp_mem = expect_mem(cpu_req);
                update_banks(cpu_req);
                pending = 1'b1;
                edges   = 0;
            end else if (pending) begin
                edges++;
                if (ack) begin
                    pending  = 1'b0;
                    acked    = 1'b1;
                    held_mem = mem;
                    if (edges - 1 != 2) begin
                        report_failure($sformatf("ack rose %0d cycles after req, not 2",
                                                 edges - 1));
                    end
                    compare_value("mem.rom_cs", 32'(mem.rom_cs), 32'(exp_mem.rom_cs));
                    compare_value("mem.scc_cs", 32'(mem.scc_cs), 32'(exp_mem.scc_cs));
                    if (exp_mem.rom_cs) begin
                        compare_value("mem.addr", 32'(mem.addr), 32'(exp_mem.addr));
                    end
                end else if (edges > 6) begin
                    report_failure("ack never came for a request");
                    pending = 1'b0;
                end
            end else if (acked) begin
                if (!ack) begin
                    acked = 1'b0;
                end else begin
                    compare_value("mem while ack high", 32'(mem), 32'(held_mem));
                    if (!req_prev) begin
                        report_failure("ack stayed high after req was dropped");
                    end
                end
            end else if (ack) begin
                report_failure("ack high with no access in flight");
            end
            req_prev = req;
        end
    end

endmodule

`default_nettype wire

/* dv/tb_cart_mapper.sv */
`default_nettype none

`include "cart_mapper_params.svh"

module tb_cart_mapper;

    timeunit 1ns;
    timeprecision 100ps;

    import cart_mapper_pkg::*;

    localparam int NUM_TESTS    = 7;
    localparam int ACCESSES     = 200;
    localparam int RESET_CYCLES = 10;
    // About 8 cycles per access incl. hold, doubled as margin
    localparam int CYCLE_LIMIT  = 2 * NUM_TESTS * (ACCESSES * 8 + RESET_CYCLES + 4);

    logic       clk = 1'b0;
    logic       arst_n;
    block_cfg_t cfg;
    logic       req;
    cpu_req_t   cpu_req;
    logic       ack;
    mem_req_t   mem;
    integer     seed;
    int         cycle_cnt = 0;

    always #2 clk = ~clk;      // 4 ns period

    cart_mapper_top cart_mapper_top_i (.clk, .arst_n, .cfg, .req, .cpu_req, .ack, .mem);

    cart_mapper_checker checker_i (.clk, .arst_n, .cfg, .req, .cpu_req, .ack, .mem);

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, run stopped", cycle_cnt);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    function automatic logic [15:0] read_addr(input mapper_type_e mapper);
        logic [15:0] r;
        logic [15:0] a;
        r = 16'(rand_below(65536));
        if (rand_below(8) == 0) begin
            a = r;                                  // Anywhere, incl. outside cartridge
        end else if (mapper == map_konami_scc && rand_below(3) == 0) begin
            a = 16'h9800 | (r & 16'h07FF);          // Sound-chip window
        end else begin
            a = 16'h4000 + (r & 16'h7FFF);
        end
        return a;
    endfunction

    function automatic logic [15:0] write_addr(input mapper_type_e mapper);
        logic [15:0] r;
        logic [15:0] a;
        r = 16'(rand_below(65536));
        if (rand_below(4) == 0) begin
            a = r;                                  // Mostly misses the registers
        end else begin
            case (mapper)
                map_ascii8, map_ascii16: a = 16'h6000 | (r & 16'h1FFF);
                map_konami_scc: a = (16'h5000 + {1'b0, r[14:13], 13'h0}) | (r & 16'h07FF);
                default: a = 16'h4000 + (r & 16'h7FFF);
            endcase
        end
        return a;
    endfunction

    // cfg only changes while reset is held
    task automatic apply_reset(input mapper_type_e mapper, input logic enable);
        @(negedge clk);
        arst_n     = 1'b0;
        req        = 1'b0;
        cfg.mapper = mapper;
        cfg.enable = enable;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
    endtask

    // One four-phase access, req held for extra cycles after ack
    task automatic host_access(input logic rnw, input logic [15:0] addr,
                               input logic [7:0] data, input int hold);
        @(negedge clk);
        cpu_req.addr = addr;
        cpu_req.data = data;
        cpu_req.rnw  = rnw;
        req          = 1'b1;
        while (!ack) @(negedge clk);
        repeat (hold) @(negedge clk);
        req = 1'b0;
        while (ack) @(negedge clk);       // Next req only after ack low
    endtask

    task automatic run_test(input string name, input mapper_type_e mapper,
                            input logic enable, input int max_hold);
        int          err_start;
        logic        rnw;
        logic [15:0] addr;
        logic [7:0]  data;
        apply_reset(mapper, enable);
        err_start = checker_i.errors;
        for (int n = 0; n < ACCESSES; n++) begin
            rnw  = rand_below(3) != 0;      // Two reads per write
            addr = rnw ? read_addr(mapper) : write_addr(mapper);
            data = (rand_below(3) == 0) ? `SCC_BANK : 8'(rand_below(256));
            host_access(rnw, addr, data, rand_below(max_hold + 1));
        end
        $display("test %s: %0d accesses, %0d errors", name, ACCESSES,
                 checker_i.errors - err_start);
    endtask

    initial begin
        seed    = 32'hde9a;
        arst_n  = 1'b0;
        req     = 1'b0;
        cpu_req = '0;
        cfg     = '0;
        run_test("linear", map_linear, 1'b1, 0);
        run_test("ascii8", map_ascii8, 1'b1, 0);
        run_test("ascii16", map_ascii16, 1'b1, 0);
        run_test("konami", map_konami, 1'b1, 0);
        run_test("konami_scc", map_konami_scc, 1'b1, 0);
        run_test("held_req", map_ascii8, 1'b1, 7);
        run_test("disabled", map_konami_scc, 1'b0, 3);
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checker_i.checks,
                 checker_i.errors);
        if (checker_i.errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cart_mapper.f */
+incdir+hw
hw/cart_mapper_pkg.sv
hw/cart_req_capture.sv
hw/mapper_ascii.sv
hw/mapper_konami.sv
hw/cart_mappers.sv
hw/cart_mapper_top.sv
dv/cart_mapper_checker.sv
dv/tb_cart_mapper.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -f cart_mapper.f --top-module tb_cart_mapper -o tb_cart_mapper
output=$(./obj_dir/tb_cart_mapper)
echo "$output"

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
echo "simulation reported failures"
exit 1
